// ==== Bender.yml ====
package:
  name: acq

sources:
  - design/acq_pkg.sv
  - design/acq_regs.sv
  - design/sample_packer.sv
  - design/word_buffer.sv
  - design/burst_writer.sv
  - design/acq_top.sv
  - target: simulation
    files:
      - testbench/acq_tb.sv

// ==== design/acq_pkg.sv ====
package acq_pkg;

  // Radio front end
  localparam int ANTENNAS         = 4;
  localparam int SAMPLES_PER_WORD = 4;

  // Memory port
  localparam int DATA_WIDTH = 32;
  localparam int ADDR_WIDTH = 32;
  localparam int BURST_LEN  = 4;  // Beats per AXI4 burst
  localparam int FIFO_DEPTH = 16;
  localparam int RING_BYTES = 1024;

  // AXI response and burst codes
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;
  localparam logic [1:0] BURST_INCR  = 2'b01;

  // Register map, byte offsets
  localparam logic [ADDR_WIDTH-1:0] REG_CTRL   = 'h00;
  localparam logic [ADDR_WIDTH-1:0] REG_BASE   = 'h04;
  localparam logic [ADDR_WIDTH-1:0] REG_WORDS  = 'h08;
  localparam logic [ADDR_WIDTH-1:0] REG_DROPS  = 'h0C;
  localparam logic [ADDR_WIDTH-1:0] REG_ERRORS = 'h10;

  // One sample strobe: I bits in [3:0], Q bits in [7:4]
  typedef logic [7:0] sample_t;

  // Memory word, seen as a bus word or as four samples.
  // Sample 0 is the lowest byte and the earliest in time.
  typedef union packed {
    logic [DATA_WIDTH-1:0]              raw;
    sample_t [SAMPLES_PER_WORD-1:0]     samples;
  } acq_word_u;

endpackage

// ==== design/acq_regs.sv ====
`timescale 1ns/1ps
module acq_regs (
  input  logic                            sig_clock,
  input  logic                            arst_n_i,
  input  logic                            s_awvalid_i,
  output logic                            s_awready_o,
  input  logic [acq_pkg::ADDR_WIDTH-1:0]  s_awaddr_i,
  input  logic                            s_wvalid_i,
  output logic                            s_wready_o,
  input  logic [acq_pkg::DATA_WIDTH-1:0]  s_wdata_i,
  output logic                            s_bvalid_o,
  input  logic                            s_bready_i,
  output logic [1:0]                      s_bresp_o,
  input  logic                            s_arvalid_i,
  output logic                            s_arready_o,
  input  logic [acq_pkg::ADDR_WIDTH-1:0]  s_araddr_i,
  output logic                            s_rvalid_o,
  input  logic                            s_rready_i,
  output logic [acq_pkg::DATA_WIDTH-1:0]  s_rdata_o,
  output logic [1:0]                      s_rresp_o,
  output logic                            run_enable_o,
  output logic [acq_pkg::ADDR_WIDTH-1:0]  base_addr_o,
  input  logic [acq_pkg::DATA_WIDTH-1:0]  word_count_i,
  input  logic [acq_pkg::DATA_WIDTH-1:0]  drop_count_i,
  input  logic [acq_pkg::DATA_WIDTH-1:0]  error_count_i
);

  logic                           wr_fire;
  logic                           rd_fire;
  logic                           wr_mapped;
  logic [acq_pkg::DATA_WIDTH-1:0] rd_data;
  logic                           rd_mapped;

  // Address and data must arrive together, one write in flight
  assign wr_fire     = s_awvalid_i & s_wvalid_i & ~s_bvalid_o;
  assign s_awready_o = wr_fire;
  assign s_wready_o  = wr_fire;

  assign s_arready_o = ~s_rvalid_o;
  assign rd_fire     = s_arvalid_i & s_arready_o;

  always_comb begin
    wr_mapped = (s_awaddr_i <= acq_pkg::REG_ERRORS) && (s_awaddr_i[1:0] == 2'b00);
  end

  // Read decode, zero data on unmapped offsets
  always_comb begin
    rd_mapped = 1'b1;
    case (s_araddr_i)
      acq_pkg::REG_CTRL:   rd_data = {{(acq_pkg::DATA_WIDTH-1){1'b0}}, run_enable_o};
      acq_pkg::REG_BASE:   rd_data = base_addr_o;
      acq_pkg::REG_WORDS:  rd_data = word_count_i;
      acq_pkg::REG_DROPS:  rd_data = drop_count_i;
      acq_pkg::REG_ERRORS: rd_data = error_count_i;
      default: begin
        rd_data   = '0;
        rd_mapped = 1'b0;
      end
    endcase
  end

  always_ff @(posedge sig_clock or negedge arst_n_i) begin
    if (!arst_n_i) begin
      s_bvalid_o   <= 1'b0;
      s_rvalid_o   <= 1'b0;
      run_enable_o <= 1'b0;
      base_addr_o  <= '0;
    end else begin
      if (wr_fire) begin
        s_bvalid_o <= 1'b1;
        if (s_awaddr_i == acq_pkg::REG_CTRL) run_enable_o <= s_wdata_i[0];
        if (s_awaddr_i == acq_pkg::REG_BASE) base_addr_o <= s_wdata_i;  // Ring start
      end else if (s_bready_i) begin
        s_bvalid_o <= 1'b0;
      end
      if (rd_fire) begin
        s_rvalid_o <= 1'b1;
      end else if (s_rready_i) begin
        s_rvalid_o <= 1'b0;
      end
    end
  end

  // Response payloads
  always_ff @(posedge sig_clock) begin
    if (wr_fire) s_bresp_o <= wr_mapped ? acq_pkg::RESP_OKAY : acq_pkg::RESP_SLVERR;
    if (rd_fire) begin
      s_rdata_o <= rd_data;
      s_rresp_o <= rd_mapped ? acq_pkg::RESP_OKAY : acq_pkg::RESP_SLVERR;
    end
  end

endmodule

// ==== design/acq_top.sv ====
`timescale 1ns/1ps
module acq_top (
  input  logic                                  sig_clock,
  input  logic                                  arst_n_i,
  input  logic [acq_pkg::ANTENNAS-1:0]          sig_i_i,
  input  logic [acq_pkg::ANTENNAS-1:0]          sig_q_i,
  input  logic                                  sig_valid_i,
  // AXI4-Lite configuration port
  input  logic                                  s_awvalid_i,
  output logic                                  s_awready_o,
  input  logic [acq_pkg::ADDR_WIDTH-1:0]        s_awaddr_i,
  input  logic                                  s_wvalid_i,
  output logic                                  s_wready_o,
  input  logic [acq_pkg::DATA_WIDTH-1:0]        s_wdata_i,
  output logic                                  s_bvalid_o,
  input  logic                                  s_bready_i,
  output logic [1:0]                            s_bresp_o,
  input  logic                                  s_arvalid_i,
  output logic                                  s_arready_o,
  input  logic [acq_pkg::ADDR_WIDTH-1:0]        s_araddr_i,
  output logic                                  s_rvalid_o,
  input  logic                                  s_rready_i,
  output logic [acq_pkg::DATA_WIDTH-1:0]        s_rdata_o,
  output logic [1:0]                            s_rresp_o,
  // AXI4 raw-data write port
  output logic                                  m_awvalid_o,
  input  logic                                  m_awready_i,
  output logic [acq_pkg::ADDR_WIDTH-1:0]        m_awaddr_o,
  output logic [7:0]                            m_awlen_o,
  output logic [1:0]                            m_awburst_o,
  output logic                                  m_wvalid_o,
  input  logic                                  m_wready_i,
  output logic [acq_pkg::DATA_WIDTH-1:0]        m_wdata_o,
  output logic [acq_pkg::DATA_WIDTH/8-1:0]      m_wstrb_o,
  output logic                                  m_wlast_o,
  input  logic                                  m_bvalid_i,
  output logic                                  m_bready_o,
  input  logic [1:0]                            m_bresp_i
);

  logic                                         pk_valid;
  acq_pkg::acq_word_u                           pk_word;
  logic                                         fb_valid;
  logic                                         fb_ready;
  acq_pkg::acq_word_u                           fb_word;
  logic [$clog2(acq_pkg::FIFO_DEPTH+1)-1:0]     fb_count;
  logic                                         run_enable;
  logic [acq_pkg::ADDR_WIDTH-1:0]               base_addr;
  logic [acq_pkg::DATA_WIDTH-1:0]               word_count;
  logic [acq_pkg::DATA_WIDTH-1:0]               drop_count;
  logic [acq_pkg::DATA_WIDTH-1:0]               error_count;

  acq_regs acq_regs_inst (
    .sig_clock, .arst_n_i,
    .s_awvalid_i, .s_awready_o, .s_awaddr_i,
    .s_wvalid_i, .s_wready_o, .s_wdata_i,
    .s_bvalid_o, .s_bready_i, .s_bresp_o,
    .s_arvalid_i, .s_arready_o, .s_araddr_i,
    .s_rvalid_o, .s_rready_i, .s_rdata_o, .s_rresp_o,
    .run_enable_o  (run_enable),
    .base_addr_o   (base_addr),
    .word_count_i  (word_count),
    .drop_count_i  (drop_count),
    .error_count_i (error_count)
  );

  sample_packer sample_packer_inst (
    .sig_clock, .arst_n_i,
    .run_enable_i (run_enable),
    .sig_i_i, .sig_q_i, .sig_valid_i,
    .word_valid_o (pk_valid),
    .word_o       (pk_word)
  );

  // No back-pressure towards the radios
  word_buffer word_buffer_inst (
    .sig_clock, .arst_n_i,
    .run_enable_i (run_enable),
    .in_valid_i   (pk_valid),
    .in_word_i    (pk_word),
    .out_valid_o  (fb_valid),
    .out_ready_i  (fb_ready),
    .out_word_o   (fb_word),
    .count_o      (fb_count),
    .drop_count_o (drop_count)
  );

  burst_writer burst_writer_inst (
    .sig_clock, .arst_n_i,
    .run_enable_i  (run_enable),
    .base_addr_i   (base_addr),
    .in_valid_i    (fb_valid),
    .in_ready_o    (fb_ready),
    .in_word_i     (fb_word),
    .in_count_i    (fb_count),
    .m_awvalid_o, .m_awready_i, .m_awaddr_o, .m_awlen_o, .m_awburst_o,
    .m_wvalid_o, .m_wready_i, .m_wdata_o, .m_wstrb_o, .m_wlast_o,
    .m_bvalid_i, .m_bready_o, .m_bresp_i,
    .word_count_o  (word_count),
    .error_count_o (error_count)
  );

endmodule

// ==== design/burst_writer.sv ====
`timescale 1ns/1ps
module burst_writer (
  input  logic                                      sig_clock,
  input  logic                                      arst_n_i,
  input  logic                                      run_enable_i,
  input  logic [acq_pkg::ADDR_WIDTH-1:0]            base_addr_i,
  input  logic                                      in_valid_i,
  output logic                                      in_ready_o,
  input  acq_pkg::acq_word_u                        in_word_i,
  input  logic [$clog2(acq_pkg::FIFO_DEPTH+1)-1:0]  in_count_i,
  output logic                                      m_awvalid_o,
  input  logic                                      m_awready_i,
  output logic [acq_pkg::ADDR_WIDTH-1:0]            m_awaddr_o,
  output logic [7:0]                                m_awlen_o,
  output logic [1:0]                                m_awburst_o,
  output logic                                      m_wvalid_o,
  input  logic                                      m_wready_i,
  output logic [acq_pkg::DATA_WIDTH-1:0]            m_wdata_o,
  output logic [acq_pkg::DATA_WIDTH/8-1:0]          m_wstrb_o,
  output logic                                      m_wlast_o,
  input  logic                                      m_bvalid_i,
  output logic                                      m_bready_o,
  input  logic [1:0]                                m_bresp_i,
  output logic [acq_pkg::DATA_WIDTH-1:0]            word_count_o,
  output logic [acq_pkg::DATA_WIDTH-1:0]            error_count_o
);

  localparam int OFS_W  = $clog2(acq_pkg::RING_BYTES);
  localparam int BEAT_W = $clog2(acq_pkg::BURST_LEN);

  typedef enum logic [1:0] {ST_ADDR, ST_DATA, ST_RESP} state_e;

  state_e            state_q;
  logic [OFS_W-1:0]  offset_q;  // Byte offset into the ring
  logic [BEAT_W-1:0] beat_q;
  logic              run_q;

  assign m_awlen_o   = 8'(acq_pkg::BURST_LEN - 1);
  assign m_awburst_o = acq_pkg::BURST_INCR;
  assign m_wstrb_o   = '1;
  assign m_wdata_o   = in_word_i.raw;
  assign m_wlast_o   = (beat_q == BEAT_W'(acq_pkg::BURST_LEN - 1));
  assign m_wvalid_o  = (state_q == ST_DATA) & in_valid_i;
  assign in_ready_o  = (state_q == ST_DATA) & m_wready_i;  // Pop on W handshake
  assign m_bready_o  = (state_q == ST_RESP);

  always_ff @(posedge sig_clock or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q       <= ST_ADDR;
      m_awvalid_o   <= 1'b0;
      m_awaddr_o    <= '0;
      offset_q      <= '0;
      beat_q        <= '0;
      run_q         <= 1'b0;
      word_count_o  <= '0;
      error_count_o <= '0;
    end else begin
      run_q <= run_enable_i;
      if (run_enable_i && !run_q) begin
        offset_q      <= '0;
        word_count_o  <= '0;
        error_count_o <= '0;
      end
      case (state_q)
        ST_ADDR: begin
          if (m_awvalid_o && m_awready_i) begin
            m_awvalid_o <= 1'b0;
            beat_q      <= '0;
            state_q     <= ST_DATA;
          end else if (!m_awvalid_o && in_count_i >= acq_pkg::BURST_LEN) begin
            m_awvalid_o <= 1'b1;  // Whole burst is buffered
            m_awaddr_o  <= base_addr_i + acq_pkg::ADDR_WIDTH'(offset_q);
          end
        end
        ST_DATA: begin
          if (m_wvalid_o && m_wready_i) begin
            beat_q <= beat_q + 1'b1;
            if (m_wlast_o) state_q <= ST_RESP;
          end
        end
        default: begin
          if (m_bvalid_i) begin
            offset_q     <= offset_q + OFS_W'(acq_pkg::BURST_LEN * acq_pkg::DATA_WIDTH / 8);
            word_count_o <= word_count_o + acq_pkg::BURST_LEN;
            if (m_bresp_i != acq_pkg::RESP_OKAY) error_count_o <= error_count_o + 1'b1;
            state_q <= ST_ADDR;
          end
        end
      endcase
    end
  end

endmodule

// ==== design/sample_packer.sv ====
`timescale 1ns/1ps
module sample_packer (
  input  logic                          sig_clock,
  input  logic                          arst_n_i,
  input  logic                          run_enable_i,
  input  logic [acq_pkg::ANTENNAS-1:0]  sig_i_i,
  input  logic [acq_pkg::ANTENNAS-1:0]  sig_q_i,
  input  logic                          sig_valid_i,
  output logic                          word_valid_o,
  output acq_pkg::acq_word_u            word_o
);

  localparam int SLOT_W = $clog2(acq_pkg::SAMPLES_PER_WORD);

  logic [SLOT_W-1:0] slot_q;
  logic              take;
  logic              last_slot;
  acq_pkg::sample_t  sample;

  assign take      = sig_valid_i & run_enable_i;
  assign last_slot = (slot_q == SLOT_W'(acq_pkg::SAMPLES_PER_WORD - 1));
  assign sample    = acq_pkg::sample_t'({sig_q_i, sig_i_i});  // Q high, I low

  always_ff @(posedge sig_clock or negedge arst_n_i) begin
    if (!arst_n_i) begin
      slot_q       <= '0;
      word_valid_o <= 1'b0;
    end else begin
      word_valid_o <= take & last_slot;  // One-cycle flag per full word
      if (!run_enable_i) begin
        slot_q <= '0;  // Partial word thrown away
      end else if (take) begin
        slot_q <= slot_q + 1'b1;
      end
    end
  end

  // Each strobe lands in the next byte of the word
  always_ff @(posedge sig_clock) begin
    if (take) begin
      word_o.samples[slot_q] <= sample;
    end
  end

endmodule

// ==== design/word_buffer.sv ====
`timescale 1ns/1ps
module word_buffer (
  input  logic                                       sig_clock,
  input  logic                                       arst_n_i,
  input  logic                                       run_enable_i,
  input  logic                                       in_valid_i,
  input  acq_pkg::acq_word_u                         in_word_i,
  output logic                                       out_valid_o,
  input  logic                                       out_ready_i,
  output acq_pkg::acq_word_u                         out_word_o,
  output logic [$clog2(acq_pkg::FIFO_DEPTH+1)-1:0]   count_o,
  output logic [acq_pkg::DATA_WIDTH-1:0]             drop_count_o
);

  localparam int PTR_W = $clog2(acq_pkg::FIFO_DEPTH);

  acq_pkg::acq_word_u mem_q [acq_pkg::FIFO_DEPTH];
  logic [PTR_W-1:0]   wr_ptr_q;
  logic [PTR_W-1:0]   rd_ptr_q;
  logic               run_q;
  logic               full;
  logic               push;
  logic               pop;

  assign full        = (count_o == ($bits(count_o))'(acq_pkg::FIFO_DEPTH));
  assign push        = in_valid_i & ~full;
  assign pop         = out_valid_o & out_ready_i;
  assign out_valid_o = (count_o != '0);
  assign out_word_o  = mem_q[rd_ptr_q];

  always_ff @(posedge sig_clock or negedge arst_n_i) begin
    if (!arst_n_i) begin
      run_q        <= 1'b0;
      wr_ptr_q     <= '0;
      rd_ptr_q     <= '0;
      count_o      <= '0;
      drop_count_o <= '0;
    end else begin
      run_q <= run_enable_i;
      if (run_enable_i && !run_q) begin  // New run
        wr_ptr_q     <= '0;
        rd_ptr_q     <= '0;
        count_o      <= '0;
        drop_count_o <= '0;
      end else begin
        if (push) wr_ptr_q <= wr_ptr_q + 1'b1;  // Wraps at depth
        if (pop)  rd_ptr_q <= rd_ptr_q + 1'b1;
        count_o <= count_o + push - pop;
        if (in_valid_i && full) drop_count_o <= drop_count_o + 1'b1;
      end
    end
  end

  always_ff @(posedge sig_clock) begin
    if (push) mem_q[wr_ptr_q] <= in_word_i;
  end

endmodule

// ==== filelist.f ====
design/acq_pkg.sv
design/acq_regs.sv
design/sample_packer.sv
design/word_buffer.sv
design/burst_writer.sv
design/acq_top.sv
testbench/acq_tb.sv

// ==== testbench/acq_tb.sv ====
`timescale 1ns/1ps
module acq_tb;

  localparam int RUN_A_STROBES = 160;
  localparam int RUN_B_STROBES = 1056;  // 66 bursts so the ring wraps once
  localparam int STALL_WORDS   = 24;
  localparam int ERR_STROBES   = 64;
  localparam int IDLE_STROBES  = 32;
  localparam int TOTAL_STROBES = RUN_A_STROBES + RUN_B_STROBES + 4 * STALL_WORDS
                                 + ERR_STROBES + IDLE_STROBES;
  localparam longint TIMEOUT_NS = 64'd20 * TOTAL_STROBES * 20;

  logic                                   sig_clock;
  logic                                   arst_n_i;
  logic [acq_pkg::ANTENNAS-1:0]           sig_i_i;
  logic [acq_pkg::ANTENNAS-1:0]           sig_q_i;
  logic                                   sig_valid_i;
  logic                                   s_awvalid_i, s_awready_o, s_wvalid_i, s_wready_o;
  logic [acq_pkg::ADDR_WIDTH-1:0]         s_awaddr_i, s_araddr_i;
  logic [acq_pkg::DATA_WIDTH-1:0]         s_wdata_i, s_rdata_o;
  logic                                   s_bvalid_o, s_bready_i, s_arvalid_i, s_arready_o;
  logic                                   s_rvalid_o, s_rready_i;
  logic [1:0]                             s_bresp_o, s_rresp_o;
  logic                                   m_awvalid_o, m_awready_i, m_wvalid_o, m_wready_i;
  logic [acq_pkg::ADDR_WIDTH-1:0]         m_awaddr_o;
  logic [7:0]                             m_awlen_o;
  logic [1:0]                             m_awburst_o, m_bresp_i;
  logic [acq_pkg::DATA_WIDTH-1:0]         m_wdata_o;
  logic [acq_pkg::DATA_WIDTH/8-1:0]       m_wstrb_o;
  logic                                   m_wlast_o, m_bvalid_i, m_bready_o;

  acq_pkg::sample_t               sample_q[$];  // Samples strobed while enabled
  acq_pkg::acq_word_u             beat_q[$];    // Beats seen by the memory model
  logic [acq_pkg::DATA_WIDTH-1:0] mem_model [int unsigned];
  logic [acq_pkg::ADDR_WIDTH-1:0] exp_base;
  int                             exp_ofs;
  int                             run_bursts;
  int                             run_beats;
  logic                           recording;
  logic                           stall;
  logic                           err_mode;

  acq_top acq_top_inst (.*);

  initial begin
    sig_clock = 1'b0;
    forever #10 sig_clock = ~sig_clock;
  end

  task automatic stop_with_failure(input string why);
    if (why != "") $display("%s", why);
    $display("Some tests failed");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input acq_pkg::acq_word_u got, exp);
    if (got !== exp) begin
      $display("[ERROR] %s got %h expected %h", name, got.raw, exp.raw);
      stop_with_failure("");
    end
  endtask

  task automatic check_addr(input string name, input logic [acq_pkg::ADDR_WIDTH-1:0] got, exp);
    if (got !== exp) begin
      $display("[ERROR] %s got %h expected %h", name, got, exp);
      stop_with_failure("");
    end
  endtask

  task automatic check_count(input string name, input logic [acq_pkg::DATA_WIDTH-1:0] got, exp);
    if (got !== exp) begin
      $display("[ERROR] %s got %h expected %h", name, got, exp);
      stop_with_failure("");
    end
  endtask

  task automatic check_resp(input string name, input logic [1:0] got, exp);
    if (got !== exp) begin
      $display("[ERROR] %s got %h expected %h", name, got, exp);
      stop_with_failure("");
    end
  endtask

  // Earliest sample goes to the lowest byte
  function automatic acq_pkg::acq_word_u pack_word(input acq_pkg::sample_t s0, s1, s2, s3);
    acq_pkg::acq_word_u w;
    w.samples[0] = s0;
    w.samples[1] = s1;
    w.samples[2] = s2;
    w.samples[3] = s3;
    return w;
  endfunction

  task automatic reg_write(input logic [31:0] addr, input logic [31:0] data);
    @(posedge sig_clock);
    #2;
    s_awvalid_i = 1'b1;
    s_wvalid_i  = 1'b1;
    s_awaddr_i  = addr;
    s_wdata_i   = data;
    #1;
    while (!(s_awready_o && s_wready_o)) begin
      @(posedge sig_clock);
      #3;
    end
    @(posedge sig_clock);
    #2;
    s_awvalid_i = 1'b0;
    s_wvalid_i  = 1'b0;
    while (!s_bvalid_o) begin
      @(posedge sig_clock);
      #2;
    end
    check_resp("s_bresp_o", s_bresp_o, acq_pkg::RESP_OKAY);
    s_bready_i = 1'b1;
    @(posedge sig_clock);
    #2;
    s_bready_i = 1'b0;
  endtask

  task automatic reg_read(input logic [31:0] addr, output logic [31:0] data,
                          output logic [1:0] resp);
    @(posedge sig_clock);
    #2;
    s_arvalid_i = 1'b1;
    s_araddr_i  = addr;
    #1;
    while (!s_arready_o) begin
      @(posedge sig_clock);
      #3;
    end
    @(posedge sig_clock);
    #2;
    s_arvalid_i = 1'b0;
    while (!s_rvalid_o) begin
      @(posedge sig_clock);
      #2;
    end
    data       = s_rdata_o;
    resp       = s_rresp_o;
    s_rready_i = 1'b1;
    @(posedge sig_clock);
    #2;
    s_rready_i = 1'b0;
  endtask

  task automatic start_run();
    sample_q.delete();
    exp_ofs    = 0;  // Ring offset restarts with the run
    run_bursts = 0;
    run_beats  = 0;
    reg_write(acq_pkg::REG_CTRL, 32'd1);
    recording = 1'b1;
  endtask

  task automatic stop_run();
    recording = 1'b0;
    reg_write(acq_pkg::REG_CTRL, 32'd0);
  endtask

  // Strobes land on random cycles with chance pct per cycle
  task automatic strobe_samples(input int count, input int pct);
    int sent;
    sent = 0;
    while (sent < count) begin
      @(posedge sig_clock);
      #2;
      if ($urandom_range(99) < pct) begin
        sig_i_i     = 4'($urandom);
        sig_q_i     = 4'($urandom);
        sig_valid_i = 1'b1;
        if (recording) sample_q.push_back({sig_q_i, sig_i_i});
        sent++;
      end else begin
        sig_valid_i = 1'b0;
      end
    end
    @(posedge sig_clock);
    #2;
    sig_valid_i = 1'b0;
  endtask

  // AXI4 memory model samples at the falling edge and answers after the rising one
  always begin : memory_model
    logic                             aw_hs, w_hs, b_hs, w_last;
    logic [acq_pkg::ADDR_WIDTH-1:0]   aw_addr, cur_addr;
    logic [7:0]                       aw_len;
    logic [1:0]                       aw_burst;
    logic [acq_pkg::DATA_WIDTH-1:0]   w_data;
    logic [acq_pkg::DATA_WIDTH/8-1:0] w_strb;
    int                               beat_idx;
    @(negedge sig_clock);
    aw_hs    = m_awvalid_o && m_awready_i;
    w_hs     = m_wvalid_o && m_wready_i;
    b_hs     = m_bvalid_i && m_bready_o;
    aw_addr  = m_awaddr_o;
    aw_len   = m_awlen_o;
    aw_burst = m_awburst_o;
    w_data   = m_wdata_o;
    w_strb   = m_wstrb_o;
    w_last   = m_wlast_o;
    @(posedge sig_clock);
    #2;
    if (aw_hs) begin
      check_addr("m_awaddr_o", aw_addr, exp_base + exp_ofs);
      check_count("m_awlen_o", 32'(aw_len), acq_pkg::BURST_LEN - 1);
      check_resp("m_awburst_o", aw_burst, acq_pkg::BURST_INCR);
      exp_ofs  = (exp_ofs + 16) % acq_pkg::RING_BYTES;
      cur_addr = aw_addr;
      beat_idx = 0;
    end
    if (b_hs) begin
      m_bvalid_i = 1'b0;
      run_bursts++;
    end
    if (w_hs) begin
      check_count("m_wlast_o", 32'(w_last), 32'(beat_idx == acq_pkg::BURST_LEN - 1));
      // Full words, every byte lane enabled
      check_count("m_wstrb_o", 32'(w_strb), 32'((1 << (acq_pkg::DATA_WIDTH / 8)) - 1));
      mem_model[cur_addr + 4 * beat_idx] = w_data;
      beat_q.push_back(w_data);
      beat_idx++;
      run_beats++;
      if (w_last) begin
        m_bvalid_i = 1'b1;
        m_bresp_i  = err_mode ? acq_pkg::RESP_SLVERR : acq_pkg::RESP_OKAY;
      end
    end
    m_awready_i = !stall && ($urandom_range(3) != 0);
    m_wready_i  = !stall && ($urandom_range(3) != 0);
  end

  // Every beat must be the next four recorded samples
  always @(negedge sig_clock) begin : compare_beats
    acq_pkg::sample_t s0, s1, s2, s3;
    while (beat_q.size() != 0) begin
      if (sample_q.size() < 4) begin
        stop_with_failure("A memory beat arrived without four recorded samples");
      end else begin
        s0 = sample_q.pop_front();
        s1 = sample_q.pop_front();
        s2 = sample_q.pop_front();
        s3 = sample_q.pop_front();
        check_word("m_wdata_o", beat_q.pop_front(), pack_word(s0, s1, s2, s3));
      end
    end
  end

  initial begin : watchdog
    #(TIMEOUT_NS);
    stop_with_failure("Watchdog timeout, the tests did not finish in time");
  end

  initial begin : main
    logic [31:0] rdata;
    logic [1:0]  rresp;
    int          seed_val;
    int          beats_before;
    seed_val    = $urandom(32'h3180);
    arst_n_i    = 1'b0;
    sig_i_i     = '0;
    sig_q_i     = '0;
    sig_valid_i = 1'b0;
    s_awvalid_i = 1'b0;
    s_awaddr_i  = '0;
    s_wvalid_i  = 1'b0;
    s_wdata_i   = '0;
    s_bready_i  = 1'b0;
    s_arvalid_i = 1'b0;
    s_araddr_i  = '0;
    s_rready_i  = 1'b0;
    m_awready_i = 1'b0;
    m_wready_i  = 1'b0;
    m_bvalid_i  = 1'b0;
    m_bresp_i   = acq_pkg::RESP_OKAY;
    recording   = 1'b0;
    stall       = 1'b0;
    err_mode    = 1'b0;
    exp_ofs     = 0;
    run_bursts  = 0;
    run_beats   = 0;
    exp_base    = 32'h4000_0100;
    repeat (3) @(posedge sig_clock);
    #2 arst_n_i = 1'b1;

    // Register readback and unmapped offset
    reg_write(acq_pkg::REG_BASE, exp_base);
    reg_read(acq_pkg::REG_BASE, rdata, rresp);
    check_addr("REG_BASE", rdata, exp_base);
    check_resp("s_rresp_o", rresp, acq_pkg::RESP_OKAY);
    reg_read(32'h20, rdata, rresp);
    check_resp("s_rresp_o", rresp, acq_pkg::RESP_SLVERR);
    check_count("s_rdata_o", rdata, 32'd0);

    // Random run with random memory stalls
    start_run();
    strobe_samples(RUN_A_STROBES, 50);
    wait (run_bursts == RUN_A_STROBES / 16);
    reg_read(acq_pkg::REG_WORDS, rdata, rresp);
    check_count("REG_WORDS", rdata, RUN_A_STROBES / 4);
    stop_run();

    // Long run so the ring offset wraps
    exp_base = 32'h8000_1000;
    reg_write(acq_pkg::REG_BASE, exp_base);
    start_run();
    strobe_samples(RUN_B_STROBES, 50);
    wait (run_bursts == RUN_B_STROBES / 16);
    stop_run();

    // Buffer overflows while memory is fully stalled
    stall = 1'b1;
    mem_model.delete();
    start_run();
    strobe_samples(4 * STALL_WORDS, 100);
    repeat (4) @(posedge sig_clock);  // Packer and buffer latency
    reg_read(acq_pkg::REG_DROPS, rdata, rresp);
    check_count("REG_DROPS", rdata, STALL_WORDS - acq_pkg::FIFO_DEPTH);
    stall = 1'b0;
    wait (run_bursts == acq_pkg::FIFO_DEPTH / acq_pkg::BURST_LEN);
    check_count("beats written", run_beats, acq_pkg::FIFO_DEPTH);
    check_count("words in memory", mem_model.num(), acq_pkg::FIFO_DEPTH);
    stop_run();

    // Every burst answered with SLVERR
    err_mode = 1'b1;
    start_run();
    strobe_samples(ERR_STROBES, 50);
    wait (run_bursts == ERR_STROBES / 16);
    reg_read(acq_pkg::REG_ERRORS, rdata, rresp);
    check_count("REG_ERRORS", rdata, run_bursts);
    reg_read(acq_pkg::REG_WORDS, rdata, rresp);
    check_count("REG_WORDS", rdata, 4 * run_bursts);
    stop_run();
    beats_before = run_beats;
    strobe_samples(IDLE_STROBES, 100);
    repeat (40) @(posedge sig_clock);
    check_count("beats after disable", run_beats, beats_before);

    $display("All tests passed");
    $finish;
  end

endmodule
